// File: list.f
logic/snd_pkg.sv
logic/snd_ctrl.sv
logic/snd_lfo.sv
logic/snd_tone_osc.sv
logic/snd_lfsr.sv
logic/sound_chip.sv
bench/sound_chip_tb.sv

// File: Bender.yml
package:
  name: sound_chip

sources:
  - files:
      - logic/snd_pkg.sv
      - logic/snd_ctrl.sv
      - logic/snd_lfo.sv
      - logic/snd_tone_osc.sv
      - logic/snd_lfsr.sv
      - logic/sound_chip.sv
  - target: simulation
    files:
      - bench/sound_chip_tb.sv

// File: bench/sound_chip_tb.sv
/* Sound chip testbench */
`timescale 1ns/10ps
`default_nettype none

module sound_chip_tb
	import snd_pkg::*;
();

	localparam int TICK_DIV = 16;
	localparam int SKIP = 2;	// Edges dropped while settings settle
	localparam int VCO_RUNS = 4;
	localparam int VCO_GAPS = 4;
	localparam int LFO_GAPS = 3;
	localparam int NOISE_N = 3;
	localparam int NOISE_GAPS = 20;
	localparam int NOISE_RUN = 32;	// Longest expected run of gated-off reloads
	localparam int MOD_LFO = 8;
	localparam int MOD_SHIFT = 1;
	localparam int MOD_GAPS = 24;
	localparam int MOD_F_MAX = 9;
	localparam int MOD_SPAN = MOD_F_MAX + 1 + (4095 >> MOD_SHIFT);

	// Worst-case cycle counts per test
	localparam int RESET_COST = 16;
	localparam int BUDGET_SILENCE = RESET_COST + 13 * TICK_DIV;
	localparam int BUDGET_HANDSHAKE = RESET_COST + 18 * TICK_DIV;
	localparam int BUDGET_VCO = VCO_RUNS * (RESET_COST + (SKIP + VCO_GAPS + 1) * 64 * TICK_DIV);
	localparam int BUDGET_LFO = RESET_COST + (SKIP + LFO_GAPS + 1) * 257 * TICK_DIV;
	localparam int BUDGET_NOISE = RESET_COST +
		(SKIP + NOISE_GAPS + 1) * NOISE_RUN * (NOISE_N + 1) * TICK_DIV;
	localparam int BUDGET_MOD = RESET_COST + (SKIP + MOD_GAPS + 1) * MOD_SPAN * TICK_DIV;
	localparam int WATCHDOG_CYCLES = 2 * (BUDGET_SILENCE + BUDGET_HANDSHAKE + BUDGET_VCO +
		BUDGET_LFO + BUDGET_NOISE + BUDGET_MOD);

	logic        clk;
	logic        rst;
	logic        cfg_valid;
	snd_cfg_t    cfg;
	logic        cfg_ready;
	logic        spkr;
	logic        last_spkr;
	logic [15:0] rng_state;
	int          errors;
	int          checks;
	int          tests;

	sound_chip #(
		.TICK_DIV(TICK_DIV)
	) dut_i (
		.clk      (clk),
		.rst      (rst),
		.cfg_valid(cfg_valid),
		.cfg      (cfg),
		.cfg_ready(cfg_ready),
		.spkr     (spkr)
	);

	always #2 clk = ~clk;	// 4 ns period

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};	// Taps 16, 14, 13, 11
	endfunction

	task automatic draw_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			rng_state = lfsr_next(rng_state);
			val = (val << 1) | rng_state[0];
		end
	endtask

	// REG_MODE data, low bit first: vco_select, noise_select, shift, mixer
	function automatic logic [11:0] mode_word(input logic [2:0] mixer, input logic [2:0] shift,
		input logic noise_sel, input logic vco_sel);
		return {4'b0000, mixer, shift, noise_sel, vco_sel};
	endfunction

	task automatic report_mismatch(input string msg);
		errors++;
		$display("error @%0t ns: %s", $time, msg);
	endtask

	task automatic report_stall(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic finish_test(input string name, input int err0);
		tests++;
		$display("Test %-14s %s (%0d errors)", name, (errors == err0) ? "ok" : "FAILED",
			errors - err0);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst <= 1'b1;
		cfg_valid <= 1'b0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
	endtask

	// Called on a rising edge, holds valid until the DUT takes the write
	task automatic write_reg(input reg_addr_t reg_a, input logic [11:0] value, output int stalls);
		cfg_valid <= 1'b1;
		cfg.addr <= reg_a;
		cfg.data <= value;
		stalls = 0;
		@(posedge clk);
		while (!cfg_ready && stalls <= 4) begin
			stalls++;
			@(posedge clk);
		end
		if (!cfg_ready) begin
			report_stall("Register write was never accepted by the DUT");
		end
		cfg_valid <= 1'b0;
	endtask

	// Cycles until spkr differs from its last seen level
	task automatic next_edge(input int limit, output int gap);
		gap = 0;
		do begin
			@(posedge clk);
			gap++;
		end while (spkr === last_spkr && gap < limit);
		if (spkr === last_spkr) begin
			report_stall($sformatf("Timeout: spkr did not change within %0d cycles", limit));
			gap = -1;
		end
		last_spkr = spkr;
	endtask

	task automatic silence_after_reset();
		int err0;
		int wait_cyc;
		err0 = errors;
		apply_reset();
		@(posedge clk);
		checks += 2;
		if (spkr !== 1'b0) begin
			report_mismatch("spkr is not low right after reset");
		end
		if (cfg_ready !== 1'b1) begin
			report_mismatch("cfg_ready is not high right after reset");
		end
		wait_cyc = 1;
		while (spkr !== 1'b1 && wait_cyc < 4 * TICK_DIV) begin
			@(posedge clk);
			wait_cyc++;
		end
		// First tick TICK_DIV cycles after release, spkr registers on it
		checks++;
		if (wait_cyc != TICK_DIV + 2) begin
			report_mismatch($sformatf("spkr rose %0d cycles after reset, expected %0d",
				wait_cyc, TICK_DIV + 2));
		end
		checks++;
		for (int i = 0; i < 8 * TICK_DIV; i++) begin
			@(posedge clk);
			if (spkr !== 1'b1) begin
				report_mismatch("spkr dropped with the mixer off");
				break;
			end
		end
		finish_test("reset_silence", err0);
	endtask

	task automatic handshake_hold();
		int err0;
		int last_low;
		int lows;
		int stalls;
		int waited;
		int gap;
		err0 = errors;
		apply_reset();
		last_low = -1;
		lows = 0;
		// Cycle 0 is the first one out of reset
		for (int i = 0; i <= 10 * TICK_DIV; i++) begin
			@(posedge clk);
			if (!cfg_ready) begin
				checks++;
				if (last_low < 0 && i != TICK_DIV) begin
					report_mismatch($sformatf("first cfg_ready low in cycle %0d, expected %0d",
						i, TICK_DIV));
				end
				if (last_low >= 0 && i - last_low != TICK_DIV) begin
					report_mismatch($sformatf("cfg_ready low cycles %0d apart, expected %0d",
						i - last_low, TICK_DIV));
				end
				last_low = i;
				lows++;
			end
		end
		checks++;
		if (lows != 10) begin
			report_mismatch($sformatf("%0d cfg_ready low cycles in %0d, expected 10", lows,
				10 * TICK_DIV + 1));
		end
		// Line up so the write starts in the next closed cycle
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (cfg_ready && waited < 2 * TICK_DIV);
		repeat (TICK_DIV - 1) @(posedge clk);
		write_reg(REG_MODE, mode_word(3'b001, 3'd0, 1'b0, 1'b0), stalls);
		checks += 2;
		if (stalls != 1) begin
			report_mismatch($sformatf("held write stalled %0d cycles, expected 1", stalls));
		end
		// VCO toggles every tick at vco_freq 0, so spkr must leave its high level
		last_spkr = spkr;
		next_edge(3 * TICK_DIV, gap);
		finish_test("handshake", err0);
	endtask

	task automatic vco_tone();
		int err0;
		int f;
		int gap;
		int stalls;
		err0 = errors;
		for (int run = 0; run < VCO_RUNS; run++) begin
			draw_bits(6, f);
			apply_reset();
			write_reg(REG_VCO, 12'(f), stalls);
			write_reg(REG_MODE, mode_word(3'b001, 3'd0, 1'b0, 1'b0), stalls);
			@(posedge clk);
			last_spkr = spkr;
			repeat (SKIP) next_edge(66 * TICK_DIV, gap);
			for (int k = 0; k < VCO_GAPS; k++) begin
				next_edge(66 * TICK_DIV, gap);
				checks++;
				if (gap >= 0 && gap != (f + 1) * TICK_DIV) begin
					report_mismatch($sformatf("vco_freq %0d gave %0d cycles, expected %0d",
						f, gap, (f + 1) * TICK_DIV));
				end
			end
		end
		finish_test("vco_tone", err0);
	endtask

	task automatic lfo_tone();
		int err0;
		int gap;
		int stalls;
		err0 = errors;
		apply_reset();
		write_reg(REG_LFO, 12'd1, stalls);
		write_reg(REG_MODE, mode_word(3'b100, 3'd0, 1'b0, 1'b0), stalls);
		@(posedge clk);
		last_spkr = spkr;
		repeat (SKIP) next_edge(259 * TICK_DIV, gap);
		for (int k = 0; k < LFO_GAPS; k++) begin
			next_edge(259 * TICK_DIV, gap);
			checks++;
			if (gap >= 0 && gap != 257 * TICK_DIV) begin
				report_mismatch($sformatf("LFO edge gap %0d cycles, expected %0d",
					gap, 257 * TICK_DIV));
			end
		end
		finish_test("lfo_tone", err0);
	endtask

	task automatic noise_gating();
		int err0;
		int gap;
		int stalls;
		int base;
		logic seen_skip;
		err0 = errors;
		base = (NOISE_N + 1) * TICK_DIV;
		seen_skip = 1'b0;
		apply_reset();
		write_reg(REG_NOISE, 12'(NOISE_N), stalls);
		write_reg(REG_MODE, mode_word(3'b010, 3'd0, 1'b0, 1'b0), stalls);
		@(posedge clk);
		last_spkr = spkr;
		repeat (SKIP) next_edge(NOISE_RUN * base, gap);
		for (int k = 0; k < NOISE_GAPS; k++) begin
			next_edge(NOISE_RUN * base, gap);
			checks++;
			if (gap >= 0 && (gap == 0 || gap % base != 0)) begin
				report_mismatch($sformatf("noise gap %0d cycles is not a multiple of %0d",
					gap, base));
			end
			if (gap > base) begin
				seen_skip = 1'b1;	// LFSR gated off at least one reload
			end
		end
		checks++;
		if (!seen_skip) begin
			report_mismatch("noise output never skipped a toggle");
		end
		finish_test("noise", err0);
	endtask

	task automatic vco_modulation();
		int err0;
		int f;
		int gap;
		int ticks;
		int first;
		int stalls;
		logic differ;
		err0 = errors;
		draw_bits(3, f);
		f += 2;
		first = -1;
		differ = 1'b0;
		apply_reset();
		write_reg(REG_LFO, 12'(MOD_LFO), stalls);
		write_reg(REG_VCO, 12'(f), stalls);
		write_reg(REG_MODE, mode_word(3'b001, 3'(MOD_SHIFT), 1'b0, 1'b1), stalls);
		@(posedge clk);
		last_spkr = spkr;
		repeat (SKIP) next_edge((MOD_SPAN + 2) * TICK_DIV, gap);
		for (int k = 0; k < MOD_GAPS; k++) begin
			next_edge((MOD_SPAN + 2) * TICK_DIV, gap);
			if (gap >= 0) begin
				ticks = gap / TICK_DIV;
				checks++;
				if (gap % TICK_DIV != 0 || ticks < f + 1 ||
					ticks > f + 1 + (4095 >> MOD_SHIFT)) begin
					report_mismatch($sformatf("modulated half-period %0d cycles out of range",
						gap));
				end
				if (first < 0) begin
					first = gap;
				end else if (gap != first) begin
					differ = 1'b1;
				end
			end
		end
		checks++;
		if (!differ) begin
			report_mismatch("modulated VCO showed only one interval");
		end
		finish_test("modulation", err0);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		cfg_valid = 1'b0;
		cfg = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		last_spkr = 1'b0;
		rng_state = 16'd56239;
		silence_after_reset();
		handshake_hold();
		vco_tone();
		lfo_tone();
		noise_gating();
		vco_modulation();
		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/sound_chip.sv
/* Sound chip top level */
`timescale 1ns/10ps
`default_nettype none

module sound_chip
	import snd_pkg::*;
#(
	parameter int TICK_DIV = 16
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     cfg_valid,
	input  snd_cfg_t cfg,
	output logic     cfg_ready,
	output logic     spkr
);

	snd_settings_t settings;
	logic          tick;
	logic          lfo_state;
	delta_t        delta;
	logic          vco_state;
	logic          noise_state;
	logic          noise_reload;
	logic [15:0]   lfsr;

	snd_ctrl #(
		.TICK_DIV(TICK_DIV)
	) ctrl_i (
		.clk        (clk),
		.rst        (rst),
		.cfg_valid  (cfg_valid),
		.cfg        (cfg),
		.cfg_ready  (cfg_ready),
		.settings   (settings),
		.tick       (tick),
		.lfo_state  (lfo_state),
		.vco_state  (vco_state),
		.noise_state(noise_state),
		.spkr       (spkr)
	);

	snd_lfo lfo_i (
		.clk      (clk),
		.rst      (rst),
		.tick     (tick),
		.lfo_freq (settings.lfo_freq),
		.lfo_shift(settings.lfo_shift),
		.lfo_state(lfo_state),
		.delta    (delta)
	);

	snd_tone_osc vco_i (
		.clk     (clk),
		.rst     (rst),
		.tick    (tick),
		.freq    (settings.vco_freq),
		.modulate(settings.vco_select),
		.delta   (delta),
		.gate    (1'b1),	// Tone toggles on every reload
		.reload  (),
		.state   (vco_state)
	);

	snd_tone_osc noise_i (
		.clk     (clk),
		.rst     (rst),
		.tick    (tick),
		.freq    (settings.noise_freq),
		.modulate(settings.noise_select),
		.delta   (delta),
		.gate    (lfsr[0]),	// Random toggle gating
		.reload  (noise_reload),
		.state   (noise_state)
	);

	// Reload pulse already falls on a tick
	snd_lfsr lfsr_i (
		.clk   (clk),
		.rst   (rst),
		.enable(noise_reload),
		.lfsr  (lfsr)
	);

endmodule

`default_nettype wire

// File: logic/snd_lfsr.sv
/* Noise shift register */
`timescale 1ns/10ps
`default_nettype none

module snd_lfsr
	import snd_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        enable,
	output logic [15:0] lfsr
);

	logic feedback;

	assign feedback = ^(lfsr & LFSR_TAPS);	// XOR of tapped bits

	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr <= LFSR_SEED;
		end else if (enable) begin
			lfsr <= {feedback, lfsr[15:1]};	// Oldest bit sits at bit 0
		end
	end

	// Lockup state must be unreachable from the seed
	a_never_zero: assert property (
		@(posedge clk) disable iff (rst)
		lfsr != '0
	);

endmodule

`default_nettype wire

// File: logic/snd_tone_osc.sv
/* Square-wave tone divider */
`timescale 1ns/10ps
`default_nettype none

module snd_tone_osc
	import snd_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      tick,
	input  osc_freq_t freq,
	input  logic      modulate,
	input  delta_t    delta,
	input  logic      gate,
	output logic      reload,
	output logic      state
);

	osc_cnt_t cnt;
	osc_cnt_t load_val;
	logic     at_zero;

	assign at_zero = (cnt == '0);
	assign reload = tick & at_zero;	// One-cycle pulse on the reload tick

	// Unmodulated channels reload with the plain setting
	assign load_val = modulate ? (osc_cnt_t'(freq) + osc_cnt_t'(delta)) :
		osc_cnt_t'(freq);

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
			state <= 1'b0;
		end else if (tick) begin
			if (at_zero) begin
				cnt <= load_val;
				if (gate) begin
					state <= ~state;	// Noise skips some toggles
				end
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	// Reloaded count never goes past setting plus full delta
	a_cnt_bound: assert property (
		@(posedge clk) disable iff (rst)
		reload |=> (cnt <= osc_cnt_t'($past(freq)) + osc_cnt_t'($past(delta)))
	);

endmodule

`default_nettype wire

// File: logic/snd_lfo.sv
/* Low-frequency oscillator */
`timescale 1ns/10ps
`default_nettype none

module snd_lfo
	import snd_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      tick,
	input  lfo_freq_t lfo_freq,
	input  shift_t    lfo_shift,
	output logic      lfo_state,
	output delta_t    delta
);

	logic [17:0] lfo_cnt;
	logic [11:0] triangle;

	always_ff @(posedge clk) begin
		if (rst) begin
			lfo_cnt <= '0;
			lfo_state <= 1'b0;
		end else if (tick) begin
			if (lfo_cnt == '0) begin
				lfo_cnt <= {lfo_freq, 8'h00};	// Period scaled by 256
				lfo_state <= ~lfo_state;
			end else begin
				lfo_cnt <= lfo_cnt - 1'b1;
			end
		end
	end

	// Fold the ramp at its top bit to get a triangle
	assign triangle = lfo_cnt[17] ? ~lfo_cnt[17:6] : lfo_cnt[17:6];

	// Depth control, larger shift means shallower bend
	assign delta = triangle >> lfo_shift;

endmodule

`default_nettype wire

// File: logic/snd_ctrl.sv
/* Sound chip register bank and mixer */
`timescale 1ns/10ps
`default_nettype none

module snd_ctrl
	import snd_pkg::*;
#(
	parameter int TICK_DIV = 16
) (
	input  logic          clk,
	input  logic          rst,
	input  logic          cfg_valid,
	input  snd_cfg_t      cfg,
	output logic          cfg_ready,
	output snd_settings_t settings,
	output logic          tick,
	input  logic          lfo_state,
	input  logic          vco_state,
	input  logic          noise_state,
	output logic          spkr
);

	localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic             div_wrap;
	logic             cfg_take;
	snd_mode_t        mode;
	logic             mix_bit;

	// Sample tick divider
	assign div_wrap = (div_cnt == DIV_W'(TICK_DIV - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			div_cnt <= '0;
			tick <= 1'b0;
		end else begin
			tick <= div_wrap;	// Registered, one cycle per period
			if (div_wrap) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// Writes are held off while the oscillators reload
	assign cfg_ready = ~tick;
	assign cfg_take = cfg_valid & cfg_ready;
	assign mode = snd_mode_t'(cfg.data);

	always_ff @(posedge clk) begin
		if (rst) begin
			settings <= '0;
		end else if (cfg_take) begin
			case (cfg.addr)
				REG_LFO: begin
					settings.lfo_freq <= cfg.data[9:0];	// Upper bits ignored
				end
				REG_NOISE: begin
					settings.noise_freq <= cfg.data;
				end
				REG_VCO: begin
					settings.vco_freq <= cfg.data;
				end
				REG_MODE: begin
					settings.vco_select <= mode.vco_select;
					settings.noise_select <= mode.noise_select;
					settings.lfo_shift <= mode.lfo_shift;
					settings.mixer <= mode.mixer;
				end
				default: begin
					settings <= settings;
				end
			endcase
		end
	end

	// A disabled channel passes a one into the AND
	assign mix_bit = (lfo_state | ~settings.mixer[MIX_LFO]) &
		(noise_state | ~settings.mixer[MIX_NOISE]) &
		(vco_state | ~settings.mixer[MIX_VCO]);

	always_ff @(posedge clk) begin
		if (rst) begin
			spkr <= 1'b0;
		end else if (tick) begin
			spkr <= mix_bit;	// Lags oscillator states by one tick
		end
	end

	// Port reopens in the cycle after each tick
	a_ready_one_cycle: assert property (
		@(posedge clk) disable iff (rst)
		tick |=> cfg_ready
	);

	// A waiting write keeps its request and payload
	a_cfg_held: assert property (
		@(posedge clk) disable iff (rst)
		(cfg_valid && !cfg_ready) |=> (cfg_valid && $stable(cfg))
	);

endmodule

`default_nettype wire

// File: logic/snd_pkg.sv
/* Sound chip shared types */
`default_nettype none

package snd_pkg;

	typedef logic [9:0]  lfo_freq_t;	// LFO period setting
	typedef logic [11:0] osc_freq_t;	// Half-period in ticks
	typedef logic [12:0] osc_cnt_t;	// Setting plus delta
	typedef logic [11:0] delta_t;	// Shifted triangle
	typedef logic [2:0]  shift_t;	// Modulation depth
	typedef logic [2:0]  mix_t;	// {LFO, noise, VCO}
	typedef logic [1:0]  reg_addr_t;

	localparam reg_addr_t REG_LFO   = 2'd0;
	localparam reg_addr_t REG_NOISE = 2'd1;
	localparam reg_addr_t REG_VCO   = 2'd2;
	localparam reg_addr_t REG_MODE  = 2'd3;

	// Mixer enable bit positions
	localparam int MIX_VCO   = 0;
	localparam int MIX_NOISE = 1;
	localparam int MIX_LFO   = 2;

	typedef struct packed {
		reg_addr_t   addr;
		logic [11:0] data;
	} snd_cfg_t;

	// Data layout of a REG_MODE write
	typedef struct packed {
		logic [3:0] unused;
		mix_t       mixer;
		shift_t     lfo_shift;
		logic       noise_select;	// LFO bends noise
		logic       vco_select;	// LFO bends VCO
	} snd_mode_t;

	typedef struct packed {
		lfo_freq_t lfo_freq;
		osc_freq_t noise_freq;
		osc_freq_t vco_freq;
		logic      vco_select;
		logic      noise_select;
		shift_t    lfo_shift;
		mix_t      mixer;
	} snd_settings_t;

	localparam logic [15:0] LFSR_TAPS = 16'h100B;
	localparam logic [15:0] LFSR_SEED = 16'h0001;

endpackage

`default_nettype wire
